//--- tb.f
hdl/edge_pe_pkg.sv
hdl/edge_pe_ifs.sv
hdl/edge_pe_ctrl.sv
hdl/nbr_id_buffer.sv
hdl/fv_forwarder.sv
hdl/edge_pe_top.sv
verif/edge_pe_asserts.sv
verif/tb_edge_pe.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_edge_pe -f tb.f -o sim_edge_pe

# keep running past the first assertion so the testbench reports the verdict
./obj_dir/sim_edge_pe +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation passed"

//--- verif/tb_edge_pe.sv
`default_nettype none

module tb_edge_pe import edge_pe_pkg::*; ();

    localparam int NUM_TASKS      = 10;
    localparam int TIMEOUT_CYCLES = NUM_TASKS * 400;

    logic                  clk;
    logic                  reset;
    logic                  task_valid;
    node_id_t              task_node;
    logic                  grant;
    logic                  nbr_sos;
    logic                  nbr_eos;
    logic [NBR_BEAT_W-1:0] nbr_ids;
    deg_t                  nbr_count;
    logic                  fv_sos;
    logic                  fv_eos;
    logic [FV_W-1:0]       fv_data;
    logic                  idle;
    logic                  req;
    logic                  req_type;
    node_id_t              req_node;
    logic [PE_TAG_W-1:0]   pe_tag;
    logic                  bank_sos;
    logic                  bank_eos;
    lane_t                 bank_lane0;
    lane_t                 bank_lane1;
    lane_t                 bank_lane2;
    lane_t                 bank_lane3;
    node_id_t              bank_node;
    logic                  bank_done;

    int unsigned lcg_state;

    edge_pe_top #(.PE_TAG(2'd2)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int unsigned next_rand(int unsigned bound);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) % bound;
    endfunction

    // SRAM rule for neighbor k of a target
    function automatic node_id_t nbr_of(node_id_t target, int k);
        return node_id_t'((int'(target) + k + 1) % MAX_NODE_ID);
    endfunction

    // arbiter model holds off 0 to 3 cycles and grants for one
    task automatic grant_request();
        int delay;
        delay = int'(next_rand(4));
        @(negedge clk);
        while (!req) @(negedge clk);
        repeat (delay + 1) @(posedge clk);
        grant <= 1'b1;
        @(posedge clk);
        grant <= 1'b0;
    endtask

    task automatic send_nbr_list(node_id_t target, int count);
        int                    beats;
        logic [NBR_BEAT_W-1:0] ids;
        beats = (count + IDS_PER_BEAT - 1) / IDS_PER_BEAT;
        repeat (next_rand(3)) @(posedge clk);  // leading gap
        for (int b = 0; b < beats; b++) begin
            for (int i = 0; i < IDS_PER_BEAT; i++) begin
                ids[i*NODE_W +: NODE_W] = nbr_of(target, b * IDS_PER_BEAT + i);
            end
            nbr_sos   <= (b == 0);
            nbr_eos   <= (b == beats - 1);
            nbr_ids   <= ids;
            nbr_count <= deg_t'(count);
            @(posedge clk);
        end
        nbr_sos <= 1'b0;
        nbr_eos <= 1'b0;
    endtask

    task automatic send_feature_vector(node_id_t node);
        int              beats;
        logic [FV_W-1:0] data;
        beats = 1 + int'(next_rand(3));
        for (int j = 0; j < FV_LANES; j++) begin
            data[j*LANE_W +: LANE_W] = lane_t'(int'(node) * FV_LANES + j);
        end
        repeat (next_rand(3)) @(posedge clk);
        for (int b = 0; b < beats; b++) begin
            fv_sos  <= (b == 0);
            fv_eos  <= (b == beats - 1);
            fv_data <= data;
            @(posedge clk);
        end
        fv_sos <= 1'b0;
        fv_eos <= 1'b0;
    endtask

    task automatic run_task();
        node_id_t target;
        int       count;
        target = node_id_t'(next_rand(MAX_NODE_ID));
        count  = 1 + int'(next_rand(MAX_DEGREE));
        @(negedge clk);
        while (!idle) @(negedge clk);
        @(posedge clk);
        task_valid <= 1'b1;
        task_node  <= target;
        @(posedge clk);
        task_valid <= 1'b0;
        grant_request();
        send_nbr_list(target, count);
        for (int k = 0; k < count; k++) begin
            grant_request();
            send_feature_vector(nbr_of(target, k));
        end
        @(negedge clk);
        while (!bank_done) @(negedge clk);
    endtask

    initial begin
        lcg_state  = 36254;
        reset      = 1'b1;
        task_valid = 1'b0;
        task_node  = '0;
        grant      = 1'b0;
        nbr_sos    = 1'b0;
        nbr_eos    = 1'b0;
        nbr_ids    = '0;
        nbr_count  = '0;
        fv_sos     = 1'b0;
        fv_eos     = 1'b0;
        fv_data    = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int n = 0; n < NUM_TASKS; n++) begin
            run_task();
        end
        @(negedge clk);
        if (dut.chk.fail_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "assertion failures at end of run");
        end
    end

    // stops on the first failed assertion or when the cycle budget runs out
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES && dut.chk.fail_count == 0) begin
            @(negedge clk);
            cycles++;
        end
        if (dut.chk.fail_count != 0) begin
            $display("[ERROR] %0t assertion check %0d failed", $time, dut.chk.last_fail);
        end else begin
            $display("timeout: the DUT did not finish %0d tasks within %0d cycles",
                     NUM_TASKS, TIMEOUT_CYCLES);
        end
        $display("tests failed");
        $fatal(1, "run aborted");
    end

endmodule

`default_nettype wire

//--- verif/edge_pe_asserts.sv
`default_nettype none

module edge_pe_asserts import edge_pe_pkg::*; #(
    parameter logic [PE_TAG_W-1:0] EXP_PE_TAG = '0
) (
    input wire logic            clk,
    input wire logic            reset,
    input wire logic            task_valid,
    input wire node_id_t        task_node,
    input wire logic            grant,
    input wire logic            nbr_sos,
    input wire logic            nbr_eos,
    input wire deg_t            nbr_count,
    input wire logic            fv_sos,
    input wire logic            fv_eos,
    input wire logic [FV_W-1:0] fv_data,
    input wire logic            idle,
    input wire logic            req,
    input wire logic            req_type,
    input wire node_id_t        req_node,
    input wire logic [PE_TAG_W-1:0] pe_tag,
    input wire logic            bank_sos,
    input wire logic            bank_eos,
    input wire lane_t           bank_lane0,
    input wire lane_t           bank_lane1,
    input wire lane_t           bank_lane2,
    input wire lane_t           bank_lane3,
    input wire node_id_t        bank_node,
    input wire logic            bank_done
);

    logic       seen_task;
    node_id_t   last_node;   // target of the current task
    logic       id_granted;  // neighbor-ID fetch already granted
    deg_t       fv_k;        // feature-vector requests granted so far
    deg_t       exp_count;
    deg_t       eos_cnt;
    logic       fv_active;
    logic       fv_beat;
    logic [1:0] done_due;    // last eos seen one and two cycles ago

    int fail_count = 0;
    int last_fail  = 0;

    assign fv_beat = fv_sos || fv_eos || fv_active;

    always_ff @(posedge clk) begin
        if (reset) begin
            seen_task  <= 1'b0;
            last_node  <= '0;
            id_granted <= 1'b0;
            fv_k       <= '0;
            exp_count  <= '0;
            eos_cnt    <= '0;
            fv_active  <= 1'b0;
            done_due   <= '0;
        end else begin
            if (task_valid) begin
                seen_task <= 1'b1;
            end
            if (idle && task_valid) begin
                last_node  <= task_node;
                id_granted <= 1'b0;
                fv_k       <= '0;
                eos_cnt    <= '0;
            end
            if (grant && !req_type) begin
                id_granted <= 1'b1;
            end
            if (grant && req_type) begin
                fv_k <= fv_k + deg_t'(1);
            end
            if (nbr_sos || nbr_eos) begin
                exp_count <= nbr_count;
            end
            if (fv_beat) begin
                fv_active <= !fv_eos;
            end
            if (fv_eos) begin
                eos_cnt <= eos_cnt + deg_t'(1);
            end
            done_due <= {done_due[0], fv_eos && (eos_cnt + deg_t'(1) == exp_count)};
        end
    end

    a_reset_quiet: assert property (@(posedge clk) disable iff (reset)
        !seen_task |-> idle && !req && !bank_sos && !bank_eos && !bank_done)
        else begin
            $error("[ERROR] %0t outputs not quiet before first task", $time);
            fail_count++;
            last_fail = 1;
        end

    a_id_req_node: assert property (@(posedge clk) disable iff (reset)
        req && req_type == REQ_TYPE_NBR_ID |-> req_node == last_node)
        else begin
            $error("[ERROR] %0t ID request node %0d, expected %0d", $time, req_node, last_node);
            fail_count++;
            last_fail = 2;
        end

    a_req_held: assert property (@(posedge clk) disable iff (reset)
        req |=> req || grant)
        else begin
            $error("[ERROR] %0t req dropped without grant", $time);
            fail_count++;
            last_fail = 3;
        end

    // k-th vector fetch goes to neighbor k of the target
    a_fv_req_node: assert property (@(posedge clk) disable iff (reset)
        req && id_granted |-> req_type == REQ_TYPE_FV &&
            req_node == node_id_t'(int'(last_node) + int'(fv_k) + 1))
        else begin
            $error("[ERROR] %0t FV request %0d has node %0d", $time, fv_k, req_node);
            fail_count++;
            last_fail = 4;
        end

    a_bank_beat: assert property (@(posedge clk) disable iff (reset)
        fv_beat |=> {bank_lane3, bank_lane2, bank_lane1, bank_lane0} == $past(fv_data) &&
            bank_sos == $past(fv_sos) && bank_eos == $past(fv_eos) && bank_node == last_node)
        else begin
            $error("[ERROR] %0t bank beat does not match feature-vector input", $time);
            fail_count++;
            last_fail = 5;
        end

    a_done_timing: assert property (@(posedge clk) disable iff (reset)
        bank_done == done_due[1])
        else begin
            $error("[ERROR] %0t bank_done %0b after %0d of %0d eos beats",
                   $time, bank_done, eos_cnt, exp_count);
            fail_count++;
            last_fail = 6;
        end

    a_done_node: assert property (@(posedge clk) disable iff (reset)
        bank_done |-> bank_node == last_node && idle)
        else begin
            $error("[ERROR] %0t done node %0d, expected %0d", $time, bank_node, last_node);
            fail_count++;
            last_fail = 7;
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        bank_done |=> idle && !bank_done)
        else begin
            $error("[ERROR] %0t bank_done longer than one cycle or not idle", $time);
            fail_count++;
            last_fail = 8;
        end

    a_pe_tag: assert property (@(posedge clk) disable iff (reset)
        pe_tag == EXP_PE_TAG)
        else begin
            $error("[ERROR] %0t pe_tag %0d, expected %0d", $time, pe_tag, EXP_PE_TAG);
            fail_count++;
            last_fail = 9;
        end

endmodule

bind edge_pe_top edge_pe_asserts #(.EXP_PE_TAG(2'd2)) chk (.*);

`default_nettype wire

//--- hdl/edge_pe_top.sv
`default_nettype none

module edge_pe_top import edge_pe_pkg::*; #(
    parameter logic [PE_TAG_W-1:0] PE_TAG = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  task_valid,
    input  node_id_t              task_node,
    input  logic                  grant,
    input  logic                  nbr_sos,
    input  logic                  nbr_eos,
    input  logic [NBR_BEAT_W-1:0] nbr_ids,
    input  deg_t                  nbr_count,
    input  logic                  fv_sos,
    input  logic                  fv_eos,
    input  logic [FV_W-1:0]       fv_data,
    output logic                  idle,
    output logic                  req,
    output logic                  req_type,
    output node_id_t              req_node,
    output logic [PE_TAG_W-1:0]   pe_tag,
    output logic                  bank_sos,
    output logic                  bank_eos,
    output lane_t                 bank_lane0,
    output lane_t                 bank_lane1,
    output lane_t                 bank_lane2,
    output lane_t                 bank_lane3,
    output node_id_t              bank_node,
    output logic                  bank_done
);

    nbr_list_if list_bus ();
    bank_fwd_if fwd_bus ();

    assign pe_tag = PE_TAG;  // fixed per PE instance

    edge_pe_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .task_valid (task_valid),
        .task_node  (task_node),
        .grant      (grant),
        .idle       (idle),
        .req        (req),
        .req_type   (req_type),
        .req_node   (req_node),
        .list       (list_bus),
        .fwd        (fwd_bus)
    );

    nbr_id_buffer u_nbr_buf (
        .clk       (clk),
        .reset     (reset),
        .nbr_sos   (nbr_sos),
        .nbr_eos   (nbr_eos),
        .nbr_ids   (nbr_ids),
        .nbr_count (nbr_count),
        .list      (list_bus)
    );

    fv_forwarder u_fv_fwd (
        .clk        (clk),
        .reset      (reset),
        .fv_sos     (fv_sos),
        .fv_eos     (fv_eos),
        .fv_data    (fv_data),
        .bank_sos   (bank_sos),
        .bank_eos   (bank_eos),
        .bank_lane0 (bank_lane0),
        .bank_lane1 (bank_lane1),
        .bank_lane2 (bank_lane2),
        .bank_lane3 (bank_lane3),
        .bank_node  (bank_node),
        .bank_done  (bank_done),
        .fwd        (fwd_bus)
    );

endmodule

`default_nettype wire

//--- hdl/fv_forwarder.sv
`default_nettype none

module fv_forwarder import edge_pe_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            fv_sos,
    input  logic            fv_eos,
    input  logic [FV_W-1:0] fv_data,
    output logic            bank_sos,
    output logic            bank_eos,
    output lane_t           bank_lane0,
    output lane_t           bank_lane1,
    output lane_t           bank_lane2,
    output lane_t           bank_lane3,
    output node_id_t        bank_node,
    output logic            bank_done,
    bank_fwd_if.fwd         fwd
);

    lane_t lanes [FV_LANES];
    logic  in_stream;   // between sos and eos
    logic  beat_valid;

    assign beat_valid    = fwd.forward_en && (fv_sos || fv_eos || in_stream);
    assign fwd.beat_last = fwd.forward_en && fv_eos;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_stream <= 1'b0;
            bank_sos  <= 1'b0;
            bank_eos  <= 1'b0;
            bank_done <= 1'b0;
        end else begin
            if (beat_valid) begin
                in_stream <= !fv_eos;
            end
            bank_sos  <= beat_valid && fv_sos;
            bank_eos  <= beat_valid && fv_eos;
            bank_done <= fwd.done_strobe;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid) begin
            for (int j = 0; j < FV_LANES; j++) begin
                lanes[j] <= fv_data[j*LANE_W +: LANE_W];  // low slice to lane 0
            end
        end
        if (beat_valid || fwd.done_strobe) begin
            bank_node <= fwd.target;
        end
    end

    assign bank_lane0 = lanes[0];
    assign bank_lane1 = lanes[1];
    assign bank_lane2 = lanes[2];
    assign bank_lane3 = lanes[3];

endmodule

`default_nettype wire

//--- hdl/nbr_id_buffer.sv
`default_nettype none

module nbr_id_buffer import edge_pe_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  nbr_sos,
    input  logic                  nbr_eos,
    input  logic [NBR_BEAT_W-1:0] nbr_ids,
    input  deg_t                  nbr_count,
    nbr_list_if.buffer            list
);

    node_id_t list_mem [MAX_DEGREE];

    deg_t wr_pos;   // first entry of the next beat
    deg_t count_q;
    logic beat_valid;

    // beats run back to back from sos to eos, so a nonzero
    // write position marks a middle beat
    assign beat_valid = list.capture_en && (nbr_sos || nbr_eos || (wr_pos != '0));

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_pos  <= '0;
            count_q <= '0;
        end else if (beat_valid) begin
            count_q <= nbr_count;
            if (nbr_eos) begin
                wr_pos <= '0;
            end else begin
                wr_pos <= wr_pos + deg_t'(IDS_PER_BEAT);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid) begin
            for (int i = 0; i < IDS_PER_BEAT; i++) begin
                if (int'(wr_pos) + i < MAX_DEGREE) begin
                    list_mem[wr_pos + deg_t'(i)] <= nbr_ids[i*NODE_W +: NODE_W];
                end
            end
        end
    end

    assign list.list_done = list.capture_en && nbr_eos;
    assign list.count     = count_q;
    assign list.rd_id     = list_mem[list.rd_idx];

endmodule

`default_nettype wire

//--- hdl/edge_pe_ctrl.sv
`default_nettype none

module edge_pe_ctrl import edge_pe_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     task_valid,
    input  node_id_t task_node,
    input  logic     grant,
    output logic     idle,
    output logic     req,
    output logic     req_type,
    output node_id_t req_node,
    nbr_list_if.ctrl list,
    bank_fwd_if.ctrl fwd
);

    ctrl_state_t state;
    ctrl_state_t state_nx;

    node_id_t target;  // node the task aggregates into
    deg_t     fv_idx;  // neighbor being fetched
    deg_t     fv_idx_inc;
    logic     last_nbr;

    logic in_req;
    logic task_accept;

    assign fv_idx_inc  = fv_idx + deg_t'(1);
    assign last_nbr    = (fv_idx_inc == list.count);
    assign in_req      = (state == REQ_ID) || (state == REQ_FV);
    assign task_accept = (state == IDLE) && task_valid;

    always_comb begin
        state_nx = state;
        case (state)
            IDLE: begin
                if (task_valid) begin
                    state_nx = REQ_ID;
                end
            end
            REQ_ID: begin
                if (grant) begin
                    state_nx = WAIT_ID;
                end
            end
            WAIT_ID: begin
                if (list.list_done) begin
                    state_nx = REQ_FV;
                end
            end
            REQ_FV: begin
                if (grant) begin
                    state_nx = WAIT_FV;
                end
            end
            WAIT_FV: begin
                // one neighbor's vector ends on its eos beat
                if (fwd.beat_last) begin
                    state_nx = last_nbr ? COMPLETE : REQ_FV;
                end
            end
            COMPLETE: begin
                state_nx = IDLE;
            end
            default: begin
                state_nx = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= IDLE;
            fv_idx <= '0;
        end else begin
            state <= state_nx;
            if (state == WAIT_ID && list.list_done) begin
                fv_idx <= '0;  // start from first neighbor
            end else if (state == WAIT_FV && fwd.beat_last) begin
                fv_idx <= fv_idx_inc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (task_accept) begin
            target <= task_node;
        end
    end

    assign idle = (state == IDLE);

    // request drops in the grant cycle
    assign req      = in_req && !grant;
    assign req_type = (state == REQ_FV) ? REQ_TYPE_FV : REQ_TYPE_NBR_ID;
    assign req_node = (state == REQ_FV) ? list.rd_id : target;

    assign list.capture_en = (state == WAIT_ID);
    assign list.rd_idx     = fv_idx;

    assign fwd.forward_en  = (state == WAIT_FV);
    assign fwd.target      = target;
    assign fwd.done_strobe = (state == COMPLETE);

endmodule

`default_nettype wire

//--- hdl/edge_pe_ifs.sv
`default_nettype none

// controller <-> neighbor-ID buffer
interface nbr_list_if import edge_pe_pkg::*; ();
    logic     capture_en;  // take beats from the ID stream
    deg_t     rd_idx;
    logic     list_done;   // eos beat captured this cycle
    deg_t     count;
    node_id_t rd_id;

    modport ctrl (
        output capture_en,
        output rd_idx,
        input  list_done,
        input  count,
        input  rd_id
    );

    modport buffer (
        input  capture_en,
        input  rd_idx,
        output list_done,
        output count,
        output rd_id
    );
endinterface

// controller <-> feature-vector forwarder
interface bank_fwd_if import edge_pe_pkg::*; ();
    logic     forward_en;
    node_id_t target;
    logic     done_strobe;
    logic     beat_last;  // eos beat seen while forwarding

    modport ctrl (
        output forward_en,
        output target,
        output done_strobe,
        input  beat_last
    );

    modport fwd (
        input  forward_en,
        input  target,
        input  done_strobe,
        output beat_last
    );
endinterface

`default_nettype wire

//--- hdl/edge_pe_pkg.sv
`default_nettype none

package edge_pe_pkg;

    // node addressing
    localparam int MAX_NODE_ID = 128;
    localparam int NODE_W      = $clog2(MAX_NODE_ID);

    typedef logic [NODE_W-1:0] node_id_t;

    // nine neighbor IDs packed per beat
    localparam int IDS_PER_BEAT = 9;
    localparam int NBR_BEAT_W   = IDS_PER_BEAT * NODE_W;  // 63 bits
    localparam int MAX_DEGREE   = 27;                     // three beats
    localparam int DEG_W        = $clog2(MAX_DEGREE + 1);

    typedef logic [DEG_W-1:0] deg_t;

    // feature vector beat split into lanes toward the bank
    localparam int FV_LANES = 4;
    localparam int LANE_W   = 16;
    localparam int FV_W     = FV_LANES * LANE_W;

    typedef logic [LANE_W-1:0] lane_t;

    localparam int PE_TAG_W = 2;  // four PEs share the arbiter

    // arbiter request types
    localparam logic REQ_TYPE_NBR_ID = 1'b0;
    localparam logic REQ_TYPE_FV     = 1'b1;

    typedef enum logic [2:0] {
        IDLE,
        REQ_ID,
        WAIT_ID,
        REQ_FV,
        WAIT_FV,
        COMPLETE
    } ctrl_state_t;

endpackage

`default_nettype wire
